// ==== verilog.f ====
hdl/field_pkg.sv
hdl/mult_pipe_pkg.sv
hdl/operand_if.sv
hdl/pass_multiply.sv
hdl/reduction_adder.sv
hdl/mult_pass.sv
hdl/mult_sequencer.sv
hdl/carry_squeeze.sv
hdl/field_mult.sv
tests/field_mult_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the field multiplier testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -Wno-fatal --top-module field_mult_tb \
	-Mdir "$build_dir" -f verilog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/Vfield_mult_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Test OK" "$log_file"; then
	exit 0
fi
echo "Pass message not found in $log_file"
exit 1

// ==== tests/field_mult_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// Random and edge operand testbench for the field multiplier
// Results are compared against a schoolbook multiply with the x38 fold and two squeeze rounds
module field_mult_tb;

	localparam int n_limbs = field_pkg::num_limbs;
	localparam int lw = field_pkg::limb_width;
	localparam int operand_bits = n_limbs * lw;
	localparam int done_timeout = 200;
	localparam int random_runs = 40;
	localparam int idle_cycles = 150;

	logic clk;
	logic rst;
	logic start;
	logic [operand_bits-1:0] a;
	logic [operand_bits-1:0] b;
	logic busy;
	logic done;
	logic [operand_bits-1:0] result;

	int checks;
	int errors;
	int unsigned seed_value;

	// Set once a wait for done runs out
	bit timed_out;

	field_mult DUT (
		.clk(clk),
		.rst(rst),
		.start(start),
		.a(a),
		.b(b),
		.busy(busy),
		.done(done),
		.result(result)
	);

	// 8 ns period
	always #4 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [operand_bits-1:0] model_product(
		input logic [operand_bits-1:0] x,
		input logic [operand_bits-1:0] y
	);
		longint w [n_limbs];
		longint u;
		longint xj;
		longint yk;
		logic [operand_bits-1:0] r;
		// Output word i with terms past limb 31 folded back times 38
		for (int i = 0; i < n_limbs; i++) begin
			w[i] = 0;
			for (int j = 0; j < n_limbs; j++) begin
				xj = longint'(x[j*lw +: lw]);
				yk = longint'(y[((i - j + n_limbs) % n_limbs)*lw +: lw]);
				if (j > i)
					w[i] += field_pkg::fold_factor * xj * yk;
				else
					w[i] += xj * yk;
			end
		end
		// Round one keeps 7 bits in limb 31
		u = 0;
		for (int i = 0; i < n_limbs - 1; i++) begin
			u += w[i];
			w[i] = u & 255;
			u = u >> lw;
		end
		u += w[n_limbs-1];
		w[n_limbs-1] = u & 127;
		u = field_pkg::wrap_factor * (u >> field_pkg::top_limb_bits);
		// Round two takes the top limb whole
		for (int i = 0; i < n_limbs - 1; i++) begin
			u += w[i];
			w[i] = u & 255;
			u = u >> lw;
		end
		w[n_limbs-1] = w[n_limbs-1] + u;
		for (int i = 0; i < n_limbs; i++)
			r[i*lw +: lw] = w[i][lw-1:0];
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus and checking helpers

	// Full 256-bit operand from 32-bit draws
	function automatic logic [operand_bits-1:0] random_operand();
		logic [operand_bits-1:0] v;
		for (int k = 0; k < operand_bits / 32; k++)
			v[k*32 +: 32] = $urandom;
		return v;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Error at %0t: %s expected %0h, got %0h", $time, what, expected, actual);
		end
	endtask

	// One-cycle start pulse and the busy check that follows
	task automatic start_mult(input logic [operand_bits-1:0] x, input logic [operand_bits-1:0] y);
		@(posedge clk);
		a <= x;
		b <= y;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		check_value("busy after start", 32'd1, {31'd0, busy});
	endtask

	// Poll done once per cycle until it pulses
	task automatic wait_for_done();
		int cycles;
		bit seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < done_timeout) begin
			@(negedge clk);
			if (done)
				seen = 1'b1;
			cycles++;
		end
		if (!seen) begin
			$display("Timeout: done did not arrive within %0d cycles", done_timeout);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	// All 32 result limbs against the model
	task automatic check_result(input string label, input logic [operand_bits-1:0] x,
		input logic [operand_bits-1:0] y);
		logic [operand_bits-1:0] expected;
		expected = model_product(x, y);
		for (int i = 0; i < n_limbs; i++)
			check_value($sformatf("%s limb %0d", label, i),
				{24'd0, expected[i*lw +: lw]}, {24'd0, result[i*lw +: lw]});
	endtask

	// Skipped entirely once a run has hung
	task automatic run_mult(input string label, input logic [operand_bits-1:0] x,
		input logic [operand_bits-1:0] y);
		if (!timed_out) begin
			start_mult(x, y);
			wait_for_done();
			if (!timed_out)
				check_result(label, x, y);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [operand_bits-1:0] x;
		logic [operand_bits-1:0] y;
		int done_count;
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		a = '0;
		b = '0;
		checks = 0;
		errors = 0;
		timed_out = 1'b0;
		seed_value = $urandom(32'h3137_512f);

		// Reset for 3 cycles
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		// Idle after reset
		repeat (10) begin
			@(negedge clk);
			check_value("busy while idle", 32'd0, {31'd0, busy});
			check_value("done while idle", 32'd0, {31'd0, done});
		end

		// Random operand pairs
		for (int n = 0; n < random_runs; n++) begin
			x = random_operand();
			y = random_operand();
			run_mult($sformatf("random %0d", n), x, y);
		end

		// Edge operands
		run_mult("zero", '0, '0);
		run_mult("one times x", {{(operand_bits-1){1'b0}}, 1'b1}, random_operand());
		// Maximum fold and carry
		run_mult("all 255", '1, '1);
		x = random_operand();
		y = random_operand();
		x[operand_bits-1 -: lw] = 8'hff;
		y[operand_bits-1 -: lw] = 8'hff;
		run_mult("limb 31 max", x, y);

		// Second start while busy must be dropped
		if (!timed_out) begin
			x = random_operand();
			y = random_operand();
			start_mult(x, y);
			repeat (10) @(posedge clk);
			a <= random_operand();
			b <= random_operand();
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
			wait_for_done();
		end
		if (!timed_out) begin
			check_result("ignored start", x, y);
			// No second done from the dropped start
			done_count = 0;
			repeat (idle_cycles) begin
				@(negedge clk);
				if (done)
					done_count++;
			end
			check_value("extra done pulses", 32'd0, done_count);
			check_value("busy after run", 32'd0, {31'd0, busy});
		end

		// Back-to-back runs with each start in the cycle after done
		for (int n = 0; n < 4; n++) begin
			x = random_operand();
			y = random_operand();
			run_mult($sformatf("back to back %0d", n), x, y);
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/field_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

// X25519 field multiplier, product mod 2^255 - 19 after two squeeze rounds
module field_mult (
	input wire clk,
	input wire rst,
	input wire start,
	input wire [field_pkg::num_limbs*field_pkg::limb_width-1:0] a,
	input wire [field_pkg::num_limbs*field_pkg::limb_width-1:0] b,
	output logic busy,
	output logic done,
	output logic [field_pkg::num_limbs*field_pkg::limb_width-1:0] result
);

	// Pass issue bus
	operand_if op ();

	// Result words back from the pass pipeline
	logic pass_valid;
	logic [field_pkg::word_width-1:0] pass_out;

	// Collected product towards the squeeze
	logic sq_start;
	logic [field_pkg::num_limbs-1:0][field_pkg::word_width-1:0] words;

	//////////////////////////////////////////////////////////////////////
	// Blocks

	mult_sequencer u_seq (
		.clk(clk),
		.rst(rst),
		.start(start),
		.a(a),
		.b(b),
		.busy(busy),
		.op(op.issuer),
		.out_valid(pass_valid),
		.out(pass_out),
		.sq_start(sq_start),
		.words(words),
		.done(done)
	);

	mult_pass u_pass (
		.clk(clk),
		.rst(rst),
		.op(op.pass),
		.out_valid(pass_valid),
		.out(pass_out)
	);

	carry_squeeze u_sq (
		.clk(clk),
		.rst(rst),
		.sq_start(sq_start),
		.words(words),
		.done(done),
		.result(result)
	);

endmodule

`default_nettype wire

// ==== hdl/carry_squeeze.sv ====
`timescale 1ns/1ps
`default_nettype none

// Serial carry chain, one limb per cycle
// Round one, wrap x19, round two
module carry_squeeze (
	input wire clk,
	input wire rst,
	input wire sq_start,
	input wire [field_pkg::num_limbs-1:0][field_pkg::word_width-1:0] words,
	output logic done,
	output logic [field_pkg::num_limbs*field_pkg::limb_width-1:0] result
);

	// Control
	logic running;
	logic wrap;
	logic second;
	logic [field_pkg::index_width-1:0] k;

	// Datapath
	logic [field_pkg::word_width-1:0] carry;
	logic [field_pkg::word_width-1:0] cur;
	logic [field_pkg::word_width-1:0] sum;
	logic [field_pkg::num_limbs-1:0][field_pkg::limb_width-1:0] limbs;

	assign result = limbs;

	//////////////////////////////////////////////////////////////////////
	// Limb adder

	// Round one reads product words, round two its own limbs
	always_comb begin
		if (second)
			cur = {{(field_pkg::word_width - field_pkg::limb_width){1'b0}}, limbs[k]};
		else
			cur = words[k];
		sum = cur + carry;
	end

	//////////////////////////////////////////////////////////////////////
	// Sequencing

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			wrap <= 1'b0;
			second <= 1'b0;
			k <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (sq_start) begin
				running <= 1'b1;
				wrap <= 1'b0;
				second <= 1'b0;
				k <= '0;
			end else if (wrap) begin
				// Single cycle between the rounds
				wrap <= 1'b0;
				second <= 1'b1;
			end else if (running) begin
				k <= k + 1'b1;
				if (k == '1) begin
					if (second) begin
						running <= 1'b0;
						done <= 1'b1;
					end else begin
						wrap <= 1'b1;
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Carry and limbs

	always_ff @(posedge clk) begin
		if (sq_start) begin
			carry <= '0;
		end else if (wrap) begin
			// Bits above 2^255 fold back times 19
			carry <= carry * field_pkg::wrap_factor;
		end else if (running) begin
			if (k == '1 && !second) begin
				// Limb 31 keeps 7 bits in round one
				limbs[k] <= {{(field_pkg::limb_width - field_pkg::top_limb_bits){1'b0}},
					sum[field_pkg::top_limb_bits-1:0]};
				carry <= sum >> field_pkg::top_limb_bits;
			end else begin
				// Round two limb 31 is at most 128, fits whole
				limbs[k] <= sum[field_pkg::limb_width-1:0];
				carry <= sum >> field_pkg::limb_width;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/mult_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

// Operand latch, pass issue and result word collection
module mult_sequencer (
	input wire clk,
	input wire rst,
	input wire start,
	input wire [field_pkg::num_limbs*field_pkg::limb_width-1:0] a,
	input wire [field_pkg::num_limbs*field_pkg::limb_width-1:0] b,
	output logic busy,
	operand_if.issuer op,
	input wire out_valid,
	input wire [field_pkg::word_width-1:0] out,
	output logic sq_start,
	output logic [field_pkg::num_limbs-1:0][field_pkg::word_width-1:0] words,
	input wire done
);

	// Latched operands, zero-extended
	logic [field_pkg::num_limbs-1:0][field_pkg::word_width-1:0] a_reg;
	logic [field_pkg::num_limbs-1:0][field_pkg::word_width-1:0] b_reg;

	// Issue side
	logic issuing;
	logic [field_pkg::index_width-1:0] issue_cnt;

	// Collect side, window opens when the first word can arrive
	logic [mult_pipe_pkg::pass_latency-1:0] lat_sr;
	logic [field_pkg::index_width-1:0] collect_cnt;
	logic collect;

	wire accept = start && !busy;

	//////////////////////////////////////////////////////////////////////
	// Pass issue

	assign op.en = issuing;
	assign op.i = issue_cnt;
	assign op.a = a_reg;

	// Rotate b so that limb j of a meets b[(i - j) mod 32]
	always_comb begin
		logic [field_pkg::index_width-1:0] jj;
		jj = '0;
		for (int j = 0; j < field_pkg::num_limbs; j++) begin
			// 5-bit subtract wraps mod 32
			op.b_rot[j] = b_reg[issue_cnt - jj];
			jj = jj + 1'b1;
		end
	end

	// Stray valids outside the window are dropped
	assign collect = out_valid && busy && (lat_sr == '0);

	//////////////////////////////////////////////////////////////////////
	// Control

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			issuing <= 1'b0;
			issue_cnt <= '0;
			lat_sr <= '0;
			collect_cnt <= '0;
			sq_start <= 1'b0;
		end else begin
			sq_start <= 1'b0;
			lat_sr <= lat_sr >> 1;
			if (accept) begin
				busy <= 1'b1;
				issuing <= 1'b1;
				issue_cnt <= '0;
				collect_cnt <= '0;
				lat_sr <= '1;
			end else if (done) begin
				busy <= 1'b0;
			end
			// Back-to-back issues, last one at index 31
			if (issuing) begin
				issue_cnt <= issue_cnt + 1'b1;
				if (issue_cnt == '1)
					issuing <= 1'b0;
			end
			// Words return in issue order
			if (collect) begin
				collect_cnt <= collect_cnt + 1'b1;
				if (collect_cnt == '1)
					sq_start <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Operand and result storage

	always_ff @(posedge clk) begin
		if (accept) begin
			for (int j = 0; j < field_pkg::num_limbs; j++) begin
				a_reg[j] <= {{(field_pkg::word_width - field_pkg::limb_width){1'b0}},
					a[j*field_pkg::limb_width +: field_pkg::limb_width]};
				b_reg[j] <= {{(field_pkg::word_width - field_pkg::limb_width){1'b0}},
					b[j*field_pkg::limb_width +: field_pkg::limb_width]};
			end
		end
		if (collect)
			words[collect_cnt] <= out;
	end

endmodule

`default_nettype wire

// ==== hdl/mult_pass.sv ====
`timescale 1ns/1ps
`default_nettype none

// Pass pipeline, one output word of the product per issue
// Multiply, x38 fold, then a 32 -> 8 -> 2 -> 1 adder tree
module mult_pass (
	input wire clk,
	input wire rst,
	operand_if.pass op,
	output logic out_valid,
	output logic [field_pkg::word_width-1:0] out
);

	// Multiplier stage
	logic [field_pkg::num_limbs-1:0][field_pkg::word_width-1:0] prod;
	logic [field_pkg::num_limbs-1:0] above;
	logic prod_valid;

	// Fold stage
	logic [field_pkg::num_limbs-1:0][field_pkg::word_width-1:0] fold;
	logic fold_valid;

	// Tree levels
	logic [field_pkg::num_limbs/mult_pipe_pkg::tree_fanin_a-1:0]
		[field_pkg::word_width-1:0] lvl1;
	logic lvl1_valid;
	logic [field_pkg::num_limbs/(mult_pipe_pkg::tree_fanin_a*mult_pipe_pkg::tree_fanin_a)-1:0]
		[field_pkg::word_width-1:0] lvl2;
	logic lvl2_valid;

	//////////////////////////////////////////////////////////////////////
	// Limb products

	pass_multiply u_mul (
		.clk(clk),
		.op(op),
		.prod(prod),
		.above(above),
		.prod_valid(prod_valid)
	);

	//////////////////////////////////////////////////////////////////////
	// Wrap-around fold

	always_ff @(posedge clk) begin
		if (rst)
			fold_valid <= 1'b0;
		else
			fold_valid <= prod_valid;
	end

	// Worst case 32 * 255^2 * 38 stays under 2^27
	always_ff @(posedge clk) begin
		if (prod_valid) begin
			for (int j = 0; j < field_pkg::num_limbs; j++) begin
				if (above[j])
					fold[j] <= prod[j] * field_pkg::fold_factor;
				else
					fold[j] <= prod[j];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Adder tree

	// 32 -> 8
	reduction_adder #(
		.in_blocks(field_pkg::num_limbs),
		.fanin(mult_pipe_pkg::tree_fanin_a)
	) u_lvl1 (
		.clk(clk),
		.rst(rst),
		.en(fold_valid),
		.din(fold),
		.dout_valid(lvl1_valid),
		.dout(lvl1)
	);

	// 8 -> 2
	reduction_adder #(
		.in_blocks(field_pkg::num_limbs / mult_pipe_pkg::tree_fanin_a),
		.fanin(mult_pipe_pkg::tree_fanin_a)
	) u_lvl2 (
		.clk(clk),
		.rst(rst),
		.en(lvl1_valid),
		.din(lvl1),
		.dout_valid(lvl2_valid),
		.dout(lvl2)
	);

	// 2 -> 1, final pass word
	reduction_adder #(
		.in_blocks(field_pkg::num_limbs /
			(mult_pipe_pkg::tree_fanin_a * mult_pipe_pkg::tree_fanin_a)),
		.fanin(mult_pipe_pkg::tree_fanin_b)
	) u_lvl3 (
		.clk(clk),
		.rst(rst),
		.en(lvl2_valid),
		.din(lvl2),
		.dout_valid(out_valid),
		.dout(out)
	);

endmodule

`default_nettype wire

// ==== hdl/reduction_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

// One registered level of the pass adder tree
// Each output word sums fanin adjacent input words
module reduction_adder #(
	parameter int in_blocks = 32,
	parameter int fanin = 4
) (
	input wire clk,
	input wire rst,
	input wire en,
	input wire [in_blocks-1:0][field_pkg::word_width-1:0] din,
	output logic dout_valid,
	output logic [in_blocks/fanin-1:0][field_pkg::word_width-1:0] dout
);

	// Combinational partial sums
	logic [in_blocks/fanin-1:0][field_pkg::word_width-1:0] sum;

	//////////////////////////////////////////////////////////////////////
	// Adder groups

	always_comb begin
		for (int o = 0; o < in_blocks / fanin; o++) begin
			sum[o] = '0;
			// Group o covers din[o*fanin] .. din[o*fanin + fanin - 1]
			for (int k = 0; k < fanin; k++) begin
				sum[o] = sum[o] + din[o * fanin + k];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output register

	// Valid tracks en with one cycle delay
	always_ff @(posedge clk) begin
		if (rst)
			dout_valid <= 1'b0;
		else
			dout_valid <= en;
	end

	// Data only loads on a valid word
	always_ff @(posedge clk) begin
		if (en)
			dout <= sum;
	end

endmodule

`default_nettype wire

// ==== hdl/pass_multiply.sv ====
`timescale 1ns/1ps
`default_nettype none

// First pass stage, all 32 limb products in parallel
module pass_multiply (
	input wire clk,
	operand_if.pass op,
	output logic [field_pkg::num_limbs-1:0][field_pkg::word_width-1:0] prod,
	output logic [field_pkg::num_limbs-1:0] above,
	output logic prod_valid
);

	//////////////////////////////////////////////////////////////////////
	// Stage valid

	// Follows the issue strobe, cleared once the sequencer is in reset
	always_ff @(posedge clk) begin
		prod_valid <= op.en;
	end

	//////////////////////////////////////////////////////////////////////
	// Products and fold flags

	always_ff @(posedge clk) begin
		if (op.en) begin
			for (int j = 0; j < field_pkg::num_limbs; j++) begin
				// Only the low limb bits are ever nonzero
				// 8x8 product, widened to the accumulator word
				prod[j] <= op.a[j][field_pkg::limb_width-1:0] *
					op.b_rot[j][field_pkg::limb_width-1:0];

				// Term wrapped past limb 31, needs the x38 fold
				above[j] <= (j > op.i);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/operand_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One pass issue, sequencer to pass pipeline
// No back-pressure, every cycle with en high is accepted
interface operand_if;

	// Issue strobe
	logic en;

	// Output word index of this pass
	logic [field_pkg::index_width-1:0] i;

	// Limbs of a, zero-extended to full words
	logic [field_pkg::num_limbs-1:0][field_pkg::word_width-1:0] a;

	// b_rot[j] = b[(i - j) mod 32]
	logic [field_pkg::num_limbs-1:0][field_pkg::word_width-1:0] b_rot;

	modport issuer (output en, i, a, b_rot);
	modport pass (input en, i, a, b_rot);

endinterface

`default_nettype wire

// ==== hdl/mult_pipe_pkg.sv ====
`default_nettype none

package mult_pipe_pkg;

	//////////////////////////////////////////////////////////////////////
	// Adder tree shape

	// First two levels, 32 -> 8 -> 2
	localparam int tree_fanin_a = 4;

	// Final level, 2 -> 1
	localparam int tree_fanin_b = 2;

	//////////////////////////////////////////////////////////////////////
	// Pass pipeline timing

	// Issue to result word:
	//   multiply 1, fold 1, three tree levels 1 each
	localparam int pass_latency = 5;

endpackage

`default_nettype wire

// ==== hdl/field_pkg.sv ====
`default_nettype none

package field_pkg;

	//////////////////////////////////////////////////////////////////////
	// Operand layout, radix 2^8

	// Limbs per operand, 32 x 8 = 256 bits
	localparam int num_limbs = 32;

	// Bits per input and output limb
	localparam int limb_width = 8;

	// Accumulator word per pass, also the zero-extended limb width
	localparam int word_width = 32;

	// Pass index, 2^index_width == num_limbs
	localparam int index_width = 5;

	//////////////////////////////////////////////////////////////////////
	// Reduction mod 2^255 - 19

	// 2^256 == 38 mod p, applied to terms above the diagonal
	localparam int fold_factor = 38;

	// 2^255 == 19 mod p, applied to the carry out of bit 255
	localparam int wrap_factor = 19;

	// Limb 31 holds bits 248..254 after the first round
	localparam int top_limb_bits = 7;

endpackage

`default_nettype wire
